/* hw/pcs_pkg.sv */
// PCS shared types
`default_nettype none

package pcs_pkg;

  // width of one data byte on the parallel side
  localparam int BYTE_W = 8;

  // width of one line symbol after 8b/10b coding
  localparam int SYM_W = 10;

  // width of each saturating error counter
  localparam int CNT_W = 16;

  // data byte with bit 0 as code input A and bit 7 as H
  typedef logic [BYTE_W-1:0] byte_t;

  // line symbol in transmission order with bit 0 as a and bit 9 as j
  // the ordering is a b c d e i f g h j from bit 0 upward
  typedef logic [SYM_W-1:0] symbol_t;

  // saturating error count
  typedef logic [CNT_W-1:0] err_count_t;

  // one lane of the transmit word before encoding
  typedef struct packed {
    byte_t data;
    logic  k;
  } tx_lane_t;

  // one lane of the transmit word after encoding
  typedef struct packed {
    symbol_t sym;
  } tx_sym_t;

  // one lane of the receive word after decoding, with its error flags
  typedef struct packed {
    byte_t data;
    logic  k;
    logic  code_err;
    logic  disp_err;
  } rx_lane_t;

endpackage

`default_nettype wire

/* hw/encode_8b10b.sv */
// 8b/10b symbol encoder
`default_nettype none
`timescale 1ns/1ns

module encode_8b10b (
  input  wire pcs_pkg::byte_t datain,
  input  wire                 k,
  // running disparity in, 0 is negative and 1 is positive
  input  wire                 dispin,
  output pcs_pkg::symbol_t    dataout,
  output logic                dispout
);

  // input bits A to H of the byte
  logic a, b, c, d, e, f, g, h;

  // classification of the ABCD nibble by its count of ones
  logic a_eq_b, c_eq_d;
  logic l22, l40, l04, l13, l31;

  // EDCBA = 11000 gets special handling in several 5b/6b terms
  logic x24;

  // uncomplemented 6b and 4b sub-blocks
  logic a6, b6, c6, d6, e6, i6;
  logic f4, g4, h4, j4, alt7;

  // disparity bookkeeping for the 6b sub-block
  logic pd1s6, nd1s6, pdos6, compl6, disp6;

  // disparity bookkeeping for the 4b sub-block
  logic nd1s4, pd1s4, ndos4, pdos4, compl4;

  assign {h, g, f, e, d, c, b, a} = datain;

  assign a_eq_b = (a == b);
  assign c_eq_d = (c == d);
  assign l22 = (a & b & ~c & ~d) | (c & d & ~a & ~b) | (~a_eq_b & ~c_eq_d);
  assign l40 = a & b & c & d;
  assign l04 = ~(a | b | c | d);
  assign l13 = (~a_eq_b & ~c & ~d) | (~c_eq_d & ~a & ~b);
  assign l31 = (~a_eq_b & c & d) | (~c_eq_d & a & b);
  assign x24 = e & d & ~c & ~b & ~a;

  // 5b/6b mapping for the primary (negative disparity) form
  assign a6 = a;
  assign b6 = (b & ~l40) | l04;
  assign c6 = l04 | c | x24;
  assign d6 = d & ~(a & b & c);
  assign e6 = (e | l13) & ~x24;
  // bit i covers the balanced groups plus D16 to D18, K28 and the E-set corners
  assign i6 = (l22 & ~e) | (e & ~d & ~c & ~(a & b)) | (e & l40) |
              (k & e & d & c & ~b & ~a) | (e & ~d & c & ~b & ~a);

  // codes whose primary form assumes a positive previous disparity
  assign pd1s6 = x24 | (~e & ~l22 & ~l31);
  // codes whose primary form assumes a negative previous disparity
  assign nd1s6 = k | (e & ~l22 & ~l13) | (~e & ~d & c & b & a);
  // of those, the ones that leave the disparity positive
  assign pdos6 = k | (e & ~l22 & ~l13);

  assign compl6 = (pd1s6 & ~dispin) | (nd1s6 & dispin);
  // every pd1s6 code turns + into -, so it flips along with pdos6
  assign disp6 = dispin ^ (pd1s6 | pdos6);

  // use the A7 form where P7 would make a run of five ones or zeros
  // this applies to D11, D13, D14, D17, D18, D20 and every Kx.7
  assign alt7 = f & g & h & (k | (dispin ? (~e & d & l31) : (e & ~d & l13)));

  // 3b/4b mapping
  assign f4 = f & ~alt7;
  assign g4 = g | (~f & ~g & ~h);
  assign h4 = h;
  assign j4 = (~h & (g ^ f)) | alt7;

  assign nd1s4 = f & g;
  // control codes with mixed FG also need the positive assumption
  assign pd1s4 = (~f & ~g) | (k & (f ^ g));
  assign ndos4 = ~f & ~g;
  assign pdos4 = f & g & h;

  // the 4b sub-block looks at the disparity left by the 6b sub-block
  assign compl4 = (pd1s4 & ~disp6) | (nd1s4 & disp6);
  assign dispout = disp6 ^ (ndos4 | pdos4);

  assign dataout = {j4, h4, g4, f4, i6, e6, d6, c6, b6, a6} ^
                   {{4{compl4}}, {6{compl6}}};

endmodule

`default_nettype wire

/* hw/decode_8b10b.sv */
// 8b/10b symbol decoder
`default_nettype none
`timescale 1ns/1ns

module decode_8b10b (
  input  wire pcs_pkg::symbol_t datain,
  // running disparity in, 0 is negative and 1 is positive
  input  wire                   dispin,
  output pcs_pkg::byte_t        dataout,
  output logic                  k,
  output logic                  dispout,
  output logic                  code_err,
  output logic                  disp_err
);

  // received code bits
  logic a, b, c, d, e, i, f, g, h, j;

  // abcd nibble class by count of ones
  logic a_eq_b, c_eq_d, p22, p13, p31, p40, p04;

  // disparity after the 6b sub-block
  logic disp6a, disp6a2, disp6a0, disp6b;

  // patterns where the 5 decoded bits differ from abcde
  logic m_bc, m_nbnc, m_ac, m_nanc, m_13ni, m_31i, m_13dei, m_13ne;
  logic m_nabei, m_abei, m_cdei, m_ncdei;
  logic ao, bo, co, do_, eo;

  // fghj nibble class and 3b decode
  logic f_eq_g, h_eq_j, q22, q13, q31, k28p;
  logic fo, go, ho;

  // sign of each sub-block's own imbalance
  logic disp6p, disp6n;

  assign {j, h, g, f, i, e, d, c, b, a} = datain;

  assign a_eq_b = (a == b);
  assign c_eq_d = (c == d);
  assign p22 = (a & b & ~c & ~d) | (c & d & ~a & ~b) | (~a_eq_b & ~c_eq_d);
  assign p13 = (~a_eq_b & ~c & ~d) | (~c_eq_d & ~a & ~b);
  assign p31 = (~a_eq_b & c & d) | (~c_eq_d & a & b);
  assign p40 = a & b & c & d;
  assign p04 = ~(a | b | c | d);

  // positive after four bits if p31, or p22 from a positive start
  assign disp6a = p31 | (p22 & dispin);
  assign disp6a2 = p31 & dispin;
  assign disp6a0 = p13 & ~dispin;
  assign disp6b = ((e & i & ~disp6a0) | (disp6a & (e | i)) | disp6a2 | (e & i & d)) &
                  (e | i | d);

  assign m_bc = p22 & b & c & (e == i);
  assign m_nbnc = p22 & ~b & ~c & (e == i);
  assign m_ac = p22 & a & c & (e == i);
  assign m_nanc = p22 & ~a & ~c & (e == i);
  assign m_13ni = p13 & ~i;
  assign m_31i = p31 & i;
  assign m_13dei = p13 & d & e & i;
  assign m_13ne = p13 & ~e;
  assign m_nabei = ~a & ~b & ~e & ~i;
  assign m_abei = a & b & e & i;
  assign m_cdei = c & d & e & i;
  assign m_ncdei = ~c & ~d & ~e & ~i;

  // each decoded bit is the code bit flipped by its own set of patterns
  assign ao = a ^ (m_nbnc | m_31i | m_13dei | m_nanc | m_13ne | m_abei | m_ncdei);
  assign bo = b ^ (m_bc | m_31i | m_13dei | m_ac | m_13ne | m_abei | m_ncdei);
  assign co = c ^ (m_bc | m_31i | m_13dei | m_nanc | m_13ne | m_nabei | m_ncdei);
  assign do_ = d ^ (m_nbnc | m_31i | m_13dei | m_ac | m_13ne | m_abei | m_ncdei);
  assign eo = e ^ (m_nbnc | m_13ni | m_13dei | m_nanc | m_13ne | m_nabei | m_ncdei);

  assign f_eq_g = (f == g);
  assign h_eq_j = (h == j);
  assign q22 = (f & g & ~h & ~j) | (~f & ~g & h & j) | (~f_eq_g & ~h_eq_j);
  assign q13 = (~f_eq_g & ~h & ~j) | (~h_eq_j & ~f & ~g);
  assign q31 = (~f_eq_g & h & j) | (~h_eq_j & f & g);

  assign dispout = (q31 | (disp6b & q22) | (h & j)) & (h | j);

  // K28 groups and the Kx.7 forms that only appear with alt7 encoding
  assign k = m_cdei | m_ncdei | (p13 & ~e & i & g & h & j) | (p31 & e & ~i & ~g & ~h & ~j);

  // K28 from positive disparity flips the meaning of the .1 .2 .5 .6 fghj
  assign k28p = ~(c | d | e | i);
  assign fo = (j & ~f & (h | ~g | k28p)) | (f & ~j & (~h | g | ~k28p)) |
              (k28p & g & h) | (~k28p & ~g & ~h);
  assign go = (j & ~f & (h | ~g | ~k28p)) | (f & ~j & (~h | g | k28p)) |
              (~k28p & g & h) | (k28p & ~g & ~h);
  assign ho = ((j ^ h) & ~((~f & g & ~h & j & ~k28p) | (~f & g & h & ~j & k28p) |
                           (f & ~g & ~h & j & ~k28p) | (f & ~g & h & ~j & k28p))) |
              (~f & g & h & j) | (f & ~g & ~h & ~j);

  assign dataout = {ho, go, fo, eo, do_, co, bo, ao};

  assign disp6p = (p31 & (e | i)) | (p22 & e & i);
  assign disp6n = (p13 & ~(e & i)) | (p22 & ~e & ~i);

  // illegal sub-blocks, run lengths over five and sub-blocks that do not alternate
  assign code_err = p40 | p04 | (f & g & h & j) | (~f & ~g & ~h & ~j) |
                    (p13 & ~e & ~i) | (p31 & e & i) |
                    (e & i & f & g & h) | (~e & ~i & ~f & ~g & ~h) |
                    (e & ~i & g & h & j) | (~e & i & ~g & ~h & ~j) |
                    (~p31 & e & ~i & ~g & ~h & ~j) | (~p13 & ~e & i & g & h & j) |
                    (((e & i & ~g & ~h & ~j) | (~e & ~i & g & h & j)) &
                     ~((c & d & e) | (~c & ~d & ~e))) |
                    (disp6p & q31) | (disp6n & q13) |
                    (a & b & c & ~e & ~i & ((~f & ~g) | q13)) |
                    (~a & ~b & ~c & e & i & ((f & g) | q31)) |
                    (f & g & ~h & ~j & disp6p) | (~f & ~g & h & j & disp6n) |
                    (m_cdei & ~f & ~g & ~h) | (m_ncdei & f & g & h);

  // fires on every legal code that breaks the running disparity
  assign disp_err = (dispin & disp6p) | (disp6n & ~dispin) |
                    (dispin & ~disp6n & f & g) | (dispin & a & b & c) |
                    (dispin & ~disp6n & q31) |
                    (~dispin & ~disp6p & ~f & ~g) | (~dispin & ~a & ~b & ~c) |
                    (~dispin & ~disp6p & q13) |
                    (disp6p & q31) | (disp6n & q13);

endmodule

`default_nettype wire

/* hw/lane_codec.sv */
// Single lane 8b/10b codec
`default_nettype none
`timescale 1ns/1ns

module lane_codec (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire pcs_pkg::tx_lane_t tx_lane,
  input  wire                    tx_lane_strobe,
  input  wire pcs_pkg::symbol_t  rx_sym,
  input  wire                    rx_lane_strobe,
  output pcs_pkg::tx_sym_t       tx_sym,
  output logic                   tx_sym_strobe,
  output pcs_pkg::rx_lane_t      rx_lane,
  output logic                   rx_out_strobe
);

  // running disparities, 0 means negative
  logic tx_rd;
  logic rx_rd;

  pcs_pkg::symbol_t enc_sym;
  logic             enc_rd;
  pcs_pkg::byte_t   dec_data;
  logic             dec_k;
  logic             dec_rd;
  logic             dec_code_err;
  logic             dec_disp_err;

  encode_8b10b i_encode_8b10b (
    .datain  (tx_lane.data),
    .k       (tx_lane.k),
    .dispin  (tx_rd),
    .dataout (enc_sym),
    .dispout (enc_rd)
  );

  decode_8b10b i_decode_8b10b (
    .datain   (rx_sym),
    .dispin   (rx_rd),
    .dataout  (dec_data),
    .k        (dec_k),
    .dispout  (dec_rd),
    .code_err (dec_code_err),
    .disp_err (dec_disp_err)
  );

  // each disparity only moves when its own direction carries a word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_rd         <= 1'b0;
      rx_rd         <= 1'b0;
      tx_sym_strobe <= 1'b0;
      rx_out_strobe <= 1'b0;
    end else begin
      tx_sym_strobe <= tx_lane_strobe;
      rx_out_strobe <= rx_lane_strobe;
      if (tx_lane_strobe) begin
        tx_rd <= enc_rd;
      end
      if (rx_lane_strobe) begin
        rx_rd <= dec_rd;
      end
    end
  end

  // payload registers follow the strobes
  always_ff @(posedge clk) begin
    if (tx_lane_strobe) begin
      tx_sym.sym <= enc_sym;
    end
    if (rx_lane_strobe) begin
      rx_lane <= '{data: dec_data, k: dec_k, code_err: dec_code_err,
                   disp_err: dec_disp_err};
    end
  end

  // a symbol sent on a strobe is never more than one bit off balance
  a_tx_balance : assert property (@(posedge clk) disable iff (!rst_n)
    tx_lane_strobe |=> ($countones(tx_sym.sym) inside {[4:6]}));

  // the disparity flips exactly when the symbol sent is unbalanced
  a_tx_rd_track : assert property (@(posedge clk) disable iff (!rst_n)
    tx_lane_strobe |=> (($countones(tx_sym.sym) != 5) == (tx_rd != $past(tx_rd))));

endmodule

`default_nettype wire

/* hw/lane_striper.sv */
// Wide word to lane splitter
`default_nettype none
`timescale 1ns/1ns

module lane_striper #(
  parameter int LANES
) (
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire pcs_pkg::byte_t   [LANES-1:0]  tx_data,
  input  wire                   [LANES-1:0]  tx_k,
  input  wire                                tx_strobe,
  input  wire pcs_pkg::symbol_t [LANES-1:0]  rx_symbols,
  input  wire                                rx_strobe,
  output pcs_pkg::tx_lane_t     [LANES-1:0]  tx_lanes,
  output logic                               tx_lane_strobe,
  output pcs_pkg::symbol_t      [LANES-1:0]  rx_lane_syms,
  output logic                               rx_lane_strobe
);

  // strobes are delayed one cycle to line up with the captured words
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_lane_strobe <= 1'b0;
      rx_lane_strobe <= 1'b0;
    end else begin
      tx_lane_strobe <= tx_strobe;
      rx_lane_strobe <= rx_strobe;
    end
  end

  // the words are held between strobes so each lane sees a stable input
  always_ff @(posedge clk) begin
    if (tx_strobe) begin
      for (int n = 0; n < LANES; n++) begin
        tx_lanes[n].data <= tx_data[n];
        tx_lanes[n].k    <= tx_k[n];
      end
    end
    if (rx_strobe) begin
      rx_lane_syms <= rx_symbols;
    end
  end

endmodule

`default_nettype wire

/* hw/lane_merger.sv */
// Lane merger and error counters
`default_nettype none
`timescale 1ns/1ns

module lane_merger #(
  parameter int LANES
) (
  input  wire                                 clk,
  input  wire                                 rst_n,
  input  wire pcs_pkg::tx_sym_t  [LANES-1:0]  lane_tx,
  input  wire                    [LANES-1:0]  lane_tx_strobe,
  input  wire pcs_pkg::rx_lane_t [LANES-1:0]  lane_rx,
  input  wire                    [LANES-1:0]  lane_rx_strobe,
  output pcs_pkg::symbol_t       [LANES-1:0]  tx_symbols,
  output logic                                tx_valid,
  output pcs_pkg::byte_t         [LANES-1:0]  rx_data,
  output logic                   [LANES-1:0]  rx_k,
  output logic                                rx_valid,
  output logic                   [LANES-1:0]  code_err,
  output logic                   [LANES-1:0]  disp_err,
  output pcs_pkg::err_count_t                 code_err_count,
  output pcs_pkg::err_count_t                 disp_err_count
);

  // adds the flagged lanes to a count and holds it at all ones on overflow
  function automatic pcs_pkg::err_count_t sat_add(input pcs_pkg::err_count_t cnt,
                                                  input logic [LANES-1:0] flags);
    logic [pcs_pkg::CNT_W:0] sum;
    sum = {1'b0, cnt} + (pcs_pkg::CNT_W + 1)'($countones(flags));
    return sum[pcs_pkg::CNT_W] ? '1 : sum[pcs_pkg::CNT_W-1:0];
  endfunction

  // lanes run in lockstep so lane 0 speaks for the word
  assign tx_valid = lane_tx_strobe[0];
  assign rx_valid = lane_rx_strobe[0];

  always_comb begin
    for (int n = 0; n < LANES; n++) begin
      tx_symbols[n] = lane_tx[n].sym;
      rx_data[n]    = lane_rx[n].data;
      rx_k[n]       = lane_rx[n].k;
      code_err[n]   = lane_rx[n].code_err;
      disp_err[n]   = lane_rx[n].disp_err;
    end
  end

  // counts pick up the flags of a word in the cycle after it is valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      code_err_count <= '0;
      disp_err_count <= '0;
    end else if (rx_valid) begin
      code_err_count <= sat_add(code_err_count, code_err);
      disp_err_count <= sat_add(disp_err_count, disp_err);
    end
  end

  // every codec must raise its strobes in the same cycle as lane 0
  a_tx_lockstep : assert property (@(posedge clk) disable iff (!rst_n)
    (lane_tx_strobe == '0) || (lane_tx_strobe == '1));
  a_rx_lockstep : assert property (@(posedge clk) disable iff (!rst_n)
    (lane_rx_strobe == '0) || (lane_rx_strobe == '1));

endmodule

`default_nettype wire

/* hw/pcs_top.sv */
// Multi-lane 8b/10b PCS top
`default_nettype none
`timescale 1ns/1ns

module pcs_top #(
  parameter int LANES = 4
) (
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire pcs_pkg::byte_t   [LANES-1:0]  tx_data,
  input  wire                   [LANES-1:0]  tx_k,
  input  wire                                tx_strobe,
  input  wire pcs_pkg::symbol_t [LANES-1:0]  rx_symbols,
  input  wire                                rx_strobe,
  output pcs_pkg::symbol_t      [LANES-1:0]  tx_symbols,
  output logic                               tx_valid,
  output pcs_pkg::byte_t        [LANES-1:0]  rx_data,
  output logic                  [LANES-1:0]  rx_k,
  output logic                               rx_valid,
  output logic                  [LANES-1:0]  code_err,
  output logic                  [LANES-1:0]  disp_err,
  output pcs_pkg::err_count_t                code_err_count,
  output pcs_pkg::err_count_t                disp_err_count
);

  // striper to codecs
  pcs_pkg::tx_lane_t [LANES-1:0] tx_lanes;
  logic                          tx_lane_strobe;
  pcs_pkg::symbol_t  [LANES-1:0] rx_lane_syms;
  logic                          rx_lane_strobe;

  // codecs to merger
  pcs_pkg::tx_sym_t  [LANES-1:0] lane_tx;
  logic              [LANES-1:0] lane_tx_strobe;
  pcs_pkg::rx_lane_t [LANES-1:0] lane_rx;
  logic              [LANES-1:0] lane_rx_strobe;

  lane_striper #(.LANES(LANES)) i_lane_striper (
    .clk, .rst_n, .tx_data, .tx_k, .tx_strobe, .rx_symbols, .rx_strobe,
    .tx_lanes, .tx_lane_strobe, .rx_lane_syms, .rx_lane_strobe
  );

  // one codec per lane, all fed by the same pair of strobes
  for (genvar n = 0; n < LANES; n++) begin : g_lane
    lane_codec i_lane_codec (
      .clk            (clk),
      .rst_n          (rst_n),
      .tx_lane        (tx_lanes[n]),
      .tx_lane_strobe (tx_lane_strobe),
      .rx_sym         (rx_lane_syms[n]),
      .rx_lane_strobe (rx_lane_strobe),
      .tx_sym         (lane_tx[n]),
      .tx_sym_strobe  (lane_tx_strobe[n]),
      .rx_lane        (lane_rx[n]),
      .rx_out_strobe  (lane_rx_strobe[n])
    );
  end

  lane_merger #(.LANES(LANES)) i_lane_merger (
    .clk, .rst_n, .lane_tx, .lane_tx_strobe, .lane_rx, .lane_rx_strobe,
    .tx_symbols, .tx_valid, .rx_data, .rx_k, .rx_valid, .code_err, .disp_err,
    .code_err_count, .disp_err_count
  );

endmodule

`default_nettype wire

/* test/tb_clock.sv */
// Testbench clock and reset
`default_nettype none
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset is released shortly after an edge, like every other input
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* test/tb_pcs_top.sv */
// PCS table-driven testbench
`default_nettype none
`timescale 1ns/1ns

module tb_pcs_top;

  localparam int LANES = 4;
  localparam int N_RANDOM = 200;
  // cycles a single word may take to come back through tx and rx
  localparam int DRAIN_LIMIT = 12;

  // a table row holds a tx word to loop back or raw symbols for rx
  typedef struct packed {
    logic                         inject;
    logic                         burst;
    pcs_pkg::byte_t   [LANES-1:0] data;
    logic             [LANES-1:0] k;
    pcs_pkg::symbol_t [LANES-1:0] syms;
    logic             [LANES-1:0] sym_chk;
    logic             [LANES-1:0] code_exp;
    logic             [LANES-1:0] disp_exp;
    logic                         disp_chk;
  } entry_t;

  typedef struct packed {
    pcs_pkg::symbol_t [LANES-1:0] syms;
    logic             [LANES-1:0] chk;
  } tx_exp_t;

  typedef struct packed {
    pcs_pkg::byte_t [LANES-1:0] data;
    logic           [LANES-1:0] k;
    logic                       data_chk;
    logic           [LANES-1:0] code_exp;
    logic           [LANES-1:0] disp_exp;
    logic                       disp_chk;
  } rx_exp_t;

  logic clk;
  logic rst_n;
  pcs_pkg::byte_t      [LANES-1:0] tx_data;
  logic                [LANES-1:0] tx_k;
  logic                            tx_strobe;
  pcs_pkg::symbol_t    [LANES-1:0] rx_symbols;
  logic                            rx_strobe;
  pcs_pkg::symbol_t    [LANES-1:0] tx_symbols;
  logic                            tx_valid;
  pcs_pkg::byte_t      [LANES-1:0] rx_data;
  logic                [LANES-1:0] rx_k;
  logic                            rx_valid;
  logic                [LANES-1:0] code_err;
  logic                [LANES-1:0] disp_err;
  pcs_pkg::err_count_t             code_err_count;
  pcs_pkg::err_count_t             disp_err_count;

  entry_t  table_q[$];
  string   name_q[$];
  tx_exp_t tx_exp_q[$];
  string   tx_name_q[$];
  rx_exp_t rx_exp_q[$];
  string   rx_name_q[$];
  int      tx_cyc_q[$];
  int      rx_cyc_q[$];
  logic    table_built = 1'b0;
  int      cyc = 0;
  int      value_errs = 0;
  int      other_errs = 0;
  logic [15:0] lfsr = 16'd30;
  // running disparity per lane as seen on the tx line is -1 or +1
  int      tx_rd [LANES];
  // count check for the word that was valid in the previous cycle
  logic    cnt_pend = 1'b0;
  string   cnt_name;
  // error counts the DUT should hold, summed from the flags expected so far
  int      code_cnt_exp = 0;
  int      disp_cnt_exp = 0;
  // cleared once a word with unchecked disparity flags has gone by
  logic    disp_cnt_known = 1'b1;

  tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(5)) i_tb_clock (.clk(clk), .rst_n(rst_n));

  pcs_top #(.LANES(LANES)) i_pcs_top (
    .clk, .rst_n, .tx_data, .tx_k, .tx_strobe, .rx_symbols, .rx_strobe,
    .tx_symbols, .tx_valid, .rx_data, .rx_k, .rx_valid, .code_err, .disp_err,
    .code_err_count, .disp_err_count
  );

  // taps x^16 + x^14 + x^13 + x^11 + 1 with the new bit entering at bit 0
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_byte(output pcs_pkg::byte_t v);
    for (int b = 0; b < 8; b++) begin
      lfsr = lfsr_next(lfsr);
      v[b] = lfsr[0];
    end
  endtask

  function automatic entry_t tx_word(input pcs_pkg::byte_t [LANES-1:0] d,
                                     input logic [LANES-1:0] kk,
                                     input pcs_pkg::symbol_t [LANES-1:0] syms,
                                     input logic [LANES-1:0] chk);
    entry_t e;
    e = '0;
    e.data = d;
    e.k = kk;
    e.syms = syms;
    e.sym_chk = chk;
    e.disp_chk = 1'b1;
    return e;
  endfunction

  function automatic entry_t raw_symbols(input pcs_pkg::symbol_t [LANES-1:0] syms,
                                         input logic [LANES-1:0] code_exp,
                                         input logic [LANES-1:0] disp_exp,
                                         input logic disp_chk);
    entry_t e;
    e = '0;
    e.inject = 1'b1;
    e.syms = syms;
    e.code_exp = code_exp;
    e.disp_exp = disp_exp;
    e.disp_chk = disp_chk;
    return e;
  endfunction

  task automatic add_entry(input string nm, input entry_t e);
    name_q.push_back(nm);
    table_q.push_back(e);
  endtask

  task automatic build_table();
    entry_t e;
    // K28.5 is 001111 1010 from RD- and its complement once RD has turned positive
    add_entry("k28_5_rd_neg", tx_word({4{8'hBC}}, 4'hF, {4{10'h17C}}, 4'hF));
    add_entry("k28_5_rd_pos", tx_word({4{8'hBC}}, 4'hF, {4{10'h283}}, 4'hF));
    // every rx lane is back at RD- here, so the RD+ form of K28.5 on lane 2 is wrong
    // D21.5 on the other lanes is balanced and legal from either side
    add_entry("disp_err_lane2",
              raw_symbols({10'h155, 10'h283, 10'h155, 10'h155}, 4'h0, 4'b0100, 1'b1));
    add_entry("k28_0_to_3", tx_word({8'h7C, 8'h5C, 8'h3C, 8'h1C}, 4'hF, '0, 4'h0));
    add_entry("k28_4_to_7", tx_word({8'hFC, 8'hDC, 8'hBC, 8'h9C}, 4'hF, '0, 4'h0));
    add_entry("k23_27_29_30_7", tx_word({8'hFE, 8'hFD, 8'hFB, 8'hF7}, 4'hF, '0, 4'h0));
    e = '0;
    e.burst = 1'b1;
    add_entry("random_loopback", e);
    // illegal codes come last since they leave the rx disparity undefined
    add_entry("code_err_zeros_ones",
              raw_symbols({10'h3FF, 10'h155, 10'h000, 10'h155}, 4'b1010, 4'h0, 1'b0));
    add_entry("code_err_all_lanes",
              raw_symbols({10'h0FF, 10'h3FF, 10'h000, 10'h300}, 4'hF, 4'h0, 1'b0));
  endtask

  task automatic report_value(input string test, input string field,
                              input logic [63:0] exp, input logic [63:0] act);
    $display("ERR %s: %s expected %0h, actual %0h", test, field, exp, act);
    value_errs++;
  endtask

  // counts must equal the sum of every flag expected so far
  task automatic verify_counts();
    cnt_pend = 1'b0;
    if (int'(code_err_count) != code_cnt_exp) begin
      report_value(cnt_name, "code_err_count", 64'(code_cnt_exp), 64'(code_err_count));
    end
    if (disp_cnt_known && int'(disp_err_count) != disp_cnt_exp) begin
      report_value(cnt_name, "disp_err_count", 64'(disp_cnt_exp), 64'(disp_err_count));
    end
  endtask

  task automatic check_symbols();
    tx_exp_t te;
    string   nm;
    int      sent;
    int      ones;
    if (tx_exp_q.size() == 0 || tx_cyc_q.size() == 0) begin
      $display("tx_valid rose in cycle %0d with no word in flight", cyc);
      other_errs++;
      return;
    end
    te = tx_exp_q.pop_front();
    nm = tx_name_q.pop_front();
    sent = tx_cyc_q.pop_front();
    if (cyc != sent + 2) begin
      $display("%s: tx_valid came %0d cycles after tx_strobe instead of 2", nm, cyc - sent);
      other_errs++;
    end
    for (int n = 0; n < LANES; n++) begin
      ones = $countones(tx_symbols[n]);
      if (ones < 4 || ones > 6) begin
        $display("ERR %s: lane %0d ones count expected 4 to 6, actual %0d", nm, n, ones);
        value_errs++;
      end
      // a six-ones symbol raises RD by two and a four-ones symbol lowers it by two
      tx_rd[n] = tx_rd[n] + 2 * (ones - 5);
      if (tx_rd[n] != 1 && tx_rd[n] != -1) begin
        $display("ERR %s: lane %0d running disparity expected +1 or -1, actual %0d",
                 nm, n, tx_rd[n]);
        value_errs++;
        tx_rd[n] = (tx_rd[n] > 0) ? 1 : -1;
      end
      if (te.chk[n] && tx_symbols[n] != te.syms[n]) begin
        report_value(nm, $sformatf("lane %0d symbol", n), 64'(te.syms[n]), 64'(tx_symbols[n]));
      end
    end
  endtask

  task automatic compare_rx_word();
    rx_exp_t re;
    string   nm;
    int      sent;
    if (rx_exp_q.size() == 0 || rx_cyc_q.size() == 0) begin
      $display("rx_valid rose in cycle %0d with no word in flight", cyc);
      other_errs++;
      return;
    end
    re = rx_exp_q.pop_front();
    nm = rx_name_q.pop_front();
    sent = rx_cyc_q.pop_front();
    if (cyc != sent + 2) begin
      $display("%s: rx_valid came %0d cycles after rx_strobe instead of 2", nm, cyc - sent);
      other_errs++;
    end
    if (re.data_chk && rx_data != re.data) begin
      report_value(nm, "rx_data", 64'(re.data), 64'(rx_data));
    end
    if (re.data_chk && rx_k != re.k) begin
      report_value(nm, "rx_k", 64'(re.k), 64'(rx_k));
    end
    if (code_err != re.code_exp) begin
      report_value(nm, "code_err", 64'(re.code_exp), 64'(code_err));
    end
    if (re.disp_chk && disp_err != re.disp_exp) begin
      report_value(nm, "disp_err", 64'(re.disp_exp), 64'(disp_err));
    end
    cnt_pend = 1'b1;
    cnt_name = nm;
    code_cnt_exp += $countones(re.code_exp);
    if (re.disp_chk) begin
      disp_cnt_exp += $countones(re.disp_exp);
    end else begin
      disp_cnt_known = 1'b0;
    end
  endtask

  // called mid-cycle once inputs and registered outputs have settled
  task automatic sample_outputs();
    if (cnt_pend) verify_counts();
    if (tx_strobe) tx_cyc_q.push_back(cyc);
    if (rx_strobe) rx_cyc_q.push_back(cyc);
    if (tx_valid) check_symbols();
    if (rx_valid) compare_rx_word();
  endtask

  // one clock cycle of stimulus; without injection rx is fed from tx
  task automatic step(input logic tx_go, input pcs_pkg::byte_t [LANES-1:0] d,
                      input logic [LANES-1:0] kk, input logic inj,
                      input pcs_pkg::symbol_t [LANES-1:0] syms);
    @(posedge clk);
    #1;
    cyc++;
    tx_strobe = tx_go;
    tx_data = d;
    tx_k = kk;
    if (inj) begin
      rx_symbols = syms;
      rx_strobe = 1'b1;
    end else begin
      rx_symbols = tx_symbols;
      rx_strobe = tx_valid;
    end
    @(negedge clk);
    sample_outputs();
  endtask

  task automatic drain(input string nm);
    int waited;
    waited = 0;
    while ((tx_exp_q.size() != 0 || rx_exp_q.size() != 0 || cnt_pend) &&
           waited < DRAIN_LIMIT) begin
      step(1'b0, '0, '0, 1'b0, '0);
      waited++;
    end
    if (tx_exp_q.size() != 0 || rx_exp_q.size() != 0 || cnt_pend) begin
      $display("%s: words still in flight after %0d idle cycles", nm, DRAIN_LIMIT);
      other_errs++;
      tx_exp_q.delete();
      rx_exp_q.delete();
      tx_name_q.delete();
      rx_name_q.delete();
      tx_cyc_q.delete();
      rx_cyc_q.delete();
      cnt_pend = 1'b0;
    end
  endtask

  task automatic expect_word(input string nm, input entry_t e);
    tx_exp_t te;
    rx_exp_t re;
    te.syms = e.syms;
    te.chk = e.sym_chk;
    re.data = e.data;
    re.k = e.k;
    re.data_chk = ~e.inject;
    re.code_exp = e.code_exp;
    re.disp_exp = e.disp_exp;
    re.disp_chk = e.disp_chk;
    if (!e.inject) begin
      tx_exp_q.push_back(te);
      tx_name_q.push_back(nm);
    end
    rx_exp_q.push_back(re);
    rx_name_q.push_back(nm);
  endtask

  // LFSR words with K clear sent back to back, so two are in flight each way
  task automatic send_random(input string nm);
    pcs_pkg::byte_t [LANES-1:0] d;
    for (int w = 0; w < N_RANDOM; w++) begin
      for (int n = 0; n < LANES; n++) begin
        take_byte(d[n]);
      end
      expect_word(nm, tx_word(d, '0, '0, '0));
      step(1'b1, d, '0, 1'b0, '0);
    end
    drain(nm);
  endtask

  initial begin
    tx_data = '0;
    tx_k = '0;
    tx_strobe = 1'b0;
    rx_symbols = '0;
    rx_strobe = 1'b0;
    foreach (tx_rd[n]) tx_rd[n] = -1;
    build_table();
    table_built = 1'b1;
    @(posedge rst_n);
    @(negedge clk);
    if (tx_valid || rx_valid) begin
      report_value("reset", "tx_valid rx_valid", 64'(0), 64'({tx_valid, rx_valid}));
    end
    if (code_err_count != '0 || disp_err_count != '0) begin
      report_value("reset", "error counts", 64'(0), 64'({code_err_count, disp_err_count}));
    end
    foreach (table_q[i]) begin
      if (table_q[i].burst) begin
        send_random(name_q[i]);
      end else begin
        expect_word(name_q[i], table_q[i]);
        step(~table_q[i].inject, table_q[i].data, table_q[i].k, table_q[i].inject,
             table_q[i].syms);
        drain(name_q[i]);
      end
    end
    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // ten cycles for every table entry and every random word
  initial begin
    wait (table_built);
    repeat ((table_q.size() + N_RANDOM) * 10) @(posedge clk);
    $display("watchdog expired in cycle %0d before the table was done", cyc);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
hw/pcs_pkg.sv
hw/encode_8b10b.sv
hw/decode_8b10b.sv
hw/lane_codec.sv
hw/lane_striper.sv
hw/lane_merger.sv
hw/pcs_top.sv
test/tb_clock.sv
test/tb_pcs_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the PCS testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_pcs_top -o sim_pcs
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_pcs > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints the fail line on any failed check or timeout
if grep -q "Simulation finished: FAIL" "$LOG"; then
  exit 1
fi
exit 0
